/* all.f */
design/pool_pkg.sv
design/half_cmp_lane.sv
design/sort_sequencer.sv
design/index_network.sv
design/pool_3x3_max.sv
test/pool_props.sv
test/tb_pool.sv

/* design/half_cmp_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module half_cmp_lane #(
    parameter int COMPARE_LATENCY = 2
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          i_go,
    input  wire pool_pkg::pix_t i_a,
    input  wire pool_pkg::pix_t i_b,
    input  wire logic          i_gt,
    output logic               o_result,
    output logic               o_rdy
);

    logic                       cmp_now;
    logic [COMPARE_LATENCY-1:0] rdy_pipe;
    logic [COMPARE_LATENCY-1:0] res_pipe;

    // Less-than is greater-than with swapped operands
    assign cmp_now = i_gt ? pool_pkg::half_gt(i_a, i_b) : pool_pkg::half_gt(i_b, i_a);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy_pipe <= '0;
        end else begin
            rdy_pipe[0] <= i_go;
            for (int k = 1; k < COMPARE_LATENCY; k++) begin
                rdy_pipe[k] <= rdy_pipe[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_go) begin
            res_pipe[0] <= cmp_now; // Operands sampled with the start pulse
        end
        for (int k = 1; k < COMPARE_LATENCY; k++) begin
            res_pipe[k] <= res_pipe[k-1];
        end
    end

    assign o_result = res_pipe[COMPARE_LATENCY-1];
    assign o_rdy    = rdy_pipe[COMPARE_LATENCY-1];

endmodule

`default_nettype wire

/* design/index_network.sv */
`timescale 1ns/1ps
`default_nettype none

module index_network (
    input  wire logic                                        clk,
    input  wire logic                                        rst_n,
    input  wire logic                                        i_start,
    input  wire pool_pkg::stage_t                            i_stage,
    input  wire logic                                        i_issue,
    input  wire pool_pkg::window_t                           i_window,
    input  wire pool_pkg::lane_mask_t                        i_lane_rdy,
    input  wire pool_pkg::lane_mask_t                        i_lane_result,
    output pool_pkg::pix_t [pool_pkg::N_LANES-1:0]           o_lane_a,
    output pool_pkg::pix_t [pool_pkg::N_LANES-1:0]           o_lane_b,
    output pool_pkg::lane_mask_t                             o_lane_gt,
    output pool_pkg::lane_mask_t                             o_lane_go,
    output pool_pkg::pix_t                                   o_max
);

    localparam pool_pkg::idx_t DIRECT_SLOT = pool_pkg::idx_t'(pool_pkg::SORT_SIZE);

    pool_pkg::pix_t       pix [pool_pkg::WIN_SIZE];
    pool_pkg::idx_t       idx [pool_pkg::SORT_SIZE];
    pool_pkg::slot_row_t  slot_a;
    pool_pkg::slot_row_t  slot_b;
    pool_pkg::lane_mask_t lane_mask;
    logic                 reload;
    logic                 sort_stage;

    assign slot_a    = pool_pkg::stage_slot_a(i_stage);
    assign slot_b    = pool_pkg::stage_slot_b(i_stage);
    assign lane_mask = pool_pkg::stage_mask(i_stage);
    assign o_lane_gt = pool_pkg::stage_gt(i_stage);
    assign o_lane_go = {pool_pkg::N_LANES{i_issue}} & lane_mask;

    // Window accepted by the sequencer in the same cycle
    assign reload     = (i_stage == pool_pkg::idle) && i_start;
    assign sort_stage = (i_stage >= pool_pkg::bt1) && (i_stage <= pool_pkg::bt6);

    always_comb begin
        for (int k = 0; k < pool_pkg::WIN_SIZE; k++) begin
            pix[k] = i_window[k*pool_pkg::PIX_W +: pool_pkg::PIX_W];
        end
    end

    // Pixels are read through the sorted indices
    always_comb begin
        for (int l = 0; l < pool_pkg::N_LANES; l++) begin
            o_lane_a[l] = pix[idx[slot_a[l][2:0]]];
            if (slot_b[l] == DIRECT_SLOT) begin
                o_lane_b[l] = pix[pool_pkg::SORT_SIZE];
            end else begin
                o_lane_b[l] = pix[idx[slot_b[l][2:0]]];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < pool_pkg::SORT_SIZE; k++) begin
                idx[k] <= pool_pkg::idx_t'(k);
            end
        end else if (reload) begin
            for (int k = 0; k < pool_pkg::SORT_SIZE; k++) begin
                idx[k] <= pool_pkg::idx_t'(k);
            end
        end else if (sort_stage) begin
            for (int l = 0; l < pool_pkg::N_LANES; l++) begin
                if (i_lane_rdy[l] && lane_mask[l] && i_lane_result[l]) begin
                    idx[slot_a[l][2:0]] <= idx[slot_b[l][2:0]]; // Swap the pair
                    idx[slot_b[l][2:0]] <= idx[slot_a[l][2:0]];
                end
            end
        end
    end

    // Top of the sort against pixel 8
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_max <= '0;
        end else if ((i_stage == pool_pkg::bt7) && i_lane_rdy[0]) begin
            o_max <= i_lane_result[0] ? o_lane_a[0] : o_lane_b[0];
        end
    end

endmodule

`default_nettype wire

/* design/pool_3x3_max.sv */
`timescale 1ns/1ps
`default_nettype none

module pool_3x3_max #(
    parameter int COMPARE_LATENCY = 2
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              i_start,
    input  wire pool_pkg::window_t i_window,
    output pool_pkg::pix_t         o_max,
    output logic                   o_valid
);

    pool_pkg::stage_t                        stage;
    logic                                    issue;
    pool_pkg::lane_mask_t                    lane_rdy;
    pool_pkg::lane_mask_t                    lane_result;
    pool_pkg::lane_mask_t                    lane_gt;
    pool_pkg::lane_mask_t                    lane_go;
    pool_pkg::pix_t [pool_pkg::N_LANES-1:0]  lane_a;
    pool_pkg::pix_t [pool_pkg::N_LANES-1:0]  lane_b;

    sort_sequencer i_sort_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_start    (i_start),
        .i_lane_rdy (lane_rdy),
        .o_stage    (stage),
        .o_issue    (issue),
        .o_valid    (o_valid)
    );

    index_network i_index_network (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_start       (i_start),
        .i_stage       (stage),
        .i_issue       (issue),
        .i_window      (i_window),
        .i_lane_rdy    (lane_rdy),
        .i_lane_result (lane_result),
        .o_lane_a      (lane_a),
        .o_lane_b      (lane_b),
        .o_lane_gt     (lane_gt),
        .o_lane_go     (lane_go),
        .o_max         (o_max)
    );

    for (genvar l = 0; l < pool_pkg::N_LANES; l++) begin : g_lane
        half_cmp_lane #(
            .COMPARE_LATENCY (COMPARE_LATENCY)
        ) i_half_cmp_lane (
            .clk      (clk),
            .rst_n    (rst_n),
            .i_go     (lane_go[l]),
            .i_a      (lane_a[l]),
            .i_b      (lane_b[l]),
            .i_gt     (lane_gt[l]),
            .o_result (lane_result[l]),
            .o_rdy    (lane_rdy[l])
        );
    end

endmodule

`default_nettype wire

/* design/pool_pkg.sv */
`default_nettype none

package pool_pkg;

    localparam int PIX_W     = 16;
    localparam int WIN_SIZE  = 9;
    localparam int SORT_SIZE = 8; // Pixels 0 to 7 go through the bitonic network
    localparam int N_LANES   = 4;
    localparam int N_STAGES  = 7; // Six bitonic stages plus the final compare

    typedef logic [PIX_W-1:0] pix_t;
    typedef logic [3:0] idx_t;
    typedef logic [WIN_SIZE*PIX_W-1:0] window_t; // Pixel k at bits 16k+15:16k
    typedef logic [N_LANES-1:0] lane_mask_t;
    typedef idx_t [N_LANES-1:0] slot_row_t; // One slot number per lane

    typedef enum logic [3:0] {
        idle   = 4'd0,
        bt1    = 4'd1,
        bt2    = 4'd2,
        bt3    = 4'd3,
        bt4    = 4'd4,
        bt5    = 4'd5,
        bt6    = 4'd6,
        bt7    = 4'd7,
        finish = 4'd8
    } stage_t;

    // First operand slot of each lane
    function automatic slot_row_t stage_slot_a(input stage_t st);
        case (st)
            bt1, bt3, bt6: return {4'd6, 4'd4, 4'd2, 4'd0};
            bt2, bt5:      return {4'd5, 4'd4, 4'd1, 4'd0};
            bt4:           return {4'd3, 4'd2, 4'd1, 4'd0};
            bt7:           return {4'd0, 4'd0, 4'd0, 4'd7};
            default:       return '0;
        endcase
    endfunction

    // Second operand slot; 8 selects pixel 8 directly
    function automatic slot_row_t stage_slot_b(input stage_t st);
        case (st)
            bt1, bt3, bt6: return {4'd7, 4'd5, 4'd3, 4'd1};
            bt2, bt5:      return {4'd7, 4'd6, 4'd3, 4'd2};
            bt4:           return {4'd7, 4'd6, 4'd5, 4'd4};
            bt7:           return {4'd0, 4'd0, 4'd0, 4'd8};
            default:       return '0;
        endcase
    endfunction

    // Direction per lane, 1 is greater-than
    function automatic lane_mask_t stage_gt(input stage_t st);
        case (st)
            bt1:           return 4'b0101;
            bt2, bt3:      return 4'b0011;
            bt4, bt5, bt6: return 4'b1111;
            bt7:           return 4'b0001;
            default:       return 4'b0000;
        endcase
    endfunction

    function automatic lane_mask_t stage_mask(input stage_t st);
        case (st)
            bt1, bt2, bt3, bt4, bt5, bt6: return 4'b1111;
            bt7:                          return 4'b0001;
            default:                      return 4'b0000;
        endcase
    endfunction

    // IEEE order for non-NaN halves, both zeros compare equal
    function automatic logic half_gt(input pix_t a, input pix_t b);
        logic a_zero;
        logic b_zero;
        a_zero = (a[PIX_W-2:0] == '0);
        b_zero = (b[PIX_W-2:0] == '0);
        if (a_zero && b_zero)
            return 1'b0;
        if (a[PIX_W-1] != b[PIX_W-1])
            return b[PIX_W-1]; // Only a positive a wins
        if (a[PIX_W-1])
            return a[PIX_W-2:0] < b[PIX_W-2:0]; // Negative, smaller magnitude is larger
        return a[PIX_W-2:0] > b[PIX_W-2:0];
    endfunction

endpackage

`default_nettype wire

/* design/sort_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sort_sequencer (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                i_start,
    input  wire pool_pkg::lane_mask_t i_lane_rdy,
    output pool_pkg::stage_t         o_stage,
    output logic                     o_issue,
    output logic                     o_valid
);

    localparam pool_pkg::stage_t LAST_CMP = pool_pkg::stage_t'(pool_pkg::N_STAGES);

    pool_pkg::stage_t     state;
    pool_pkg::stage_t     state_nxt;
    pool_pkg::lane_mask_t lane_mask;
    logic                 stage_done;
    logic                 enter_cmp;

    assign lane_mask  = pool_pkg::stage_mask(state);
    assign stage_done = ((i_lane_rdy & lane_mask) == lane_mask);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pool_pkg::idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            pool_pkg::idle: begin
                if (i_start) begin
                    state_nxt = pool_pkg::bt1;
                end
            end
            pool_pkg::bt1, pool_pkg::bt2, pool_pkg::bt3, pool_pkg::bt4,
            pool_pkg::bt5, pool_pkg::bt6, pool_pkg::bt7: begin
                if (stage_done) begin
                    state_nxt = pool_pkg::stage_t'(state + 4'd1); // bt7 steps into finish
                end
            end
            pool_pkg::finish: state_nxt = pool_pkg::idle;
            default:          state_nxt = pool_pkg::idle;
        endcase
    end

    // Issue goes out in the first cycle of every compare stage
    assign enter_cmp = (state_nxt != state) &&
                       (state_nxt >= pool_pkg::bt1) && (state_nxt <= LAST_CMP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_issue <= 1'b0;
        end else begin
            o_issue <= enter_cmp;
        end
    end

    assign o_stage = state;
    assign o_valid = (state == pool_pkg::finish); // Finish lasts one cycle

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the max-pooling testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pool -f all.f -o sim_tb_pool

./obj_dir/sim_tb_pool 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* test/pool_patterns.hex */
// Each line: pixels 0 to 8 of one window, then the expected maximum
// All words are IEEE half-precision values in hex
4880 4000 4200 3800 4400 4500 4600 4700 3e00 4880
3c00 4880 4200 3800 4400 4500 4600 4700 3e00 4880
3c00 4000 4880 3800 4400 4500 4600 4700 3e00 4880
3c00 4000 4200 4880 4400 4500 4600 4700 3e00 4880
3c00 4000 4200 3800 4880 4500 4600 4700 3e00 4880
3c00 4000 4200 3800 4400 4880 4600 4700 3e00 4880
3c00 4000 4200 3800 4400 4500 4880 4700 3e00 4880
3c00 4000 4200 3800 4400 4500 4600 4880 3e00 4880
3c00 4000 4200 3800 4400 4500 4600 4700 4880 4880
bc00 c000 c200 b800 c400 c500 fc00 c600 c700 b800
c000 c200 c400 c500 c600 c700 fc00 c800 bc00 bc00
c000 3800 bc00 0001 fc00 3c00 8001 c200 b800 3c00
7c00 c000 4000 fc00 3c00 bc00 7bff 8001 0001 7c00
4200 3c00 4200 bc00 4200 c000 3800 4200 4200 4200
c000 c200 bc00 c400 bc00 c500 c600 bc00 c700 bc00
0000 bc00 c000 c200 b800 c400 c500 c600 8000 8000
bc00 8000 c000 c200 b800 c400 c500 c600 0000 0000
c000 0000 c200 c400 b800 c500 c600 c700 c800 0000
c000 c200 bc00 8000 c400 b800 c500 c600 bc00 8000

/* test/pool_props.sv */
`timescale 1ns/1ps
`default_nettype none

module pool_props (
    input wire logic           clk,
    input wire logic           rst_n,
    input wire logic           i_valid,
    input wire pool_pkg::pix_t i_max
);

    // Done is a one-cycle pulse
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) i_valid |=> !i_valid
    ) else $error("o_valid was high on two consecutive cycles");

    a_valid_in_reset: assert property (
        @(posedge clk) !rst_n |-> !i_valid
    ) else $error("o_valid was high during reset");

    // New result appears together with the finish cycle only
    a_max_hold: assert property (
        @(posedge clk) disable iff (!rst_n) !$stable(i_max) |-> i_valid
    ) else $error("o_max changed outside the finish cycle");

endmodule

bind pool_3x3_max pool_props i_pool_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (o_valid),
    .i_max   (o_max)
);

`default_nettype wire

/* test/tb_pool.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pool;

    localparam int CMP_LAT    = 2;
    localparam int LATENCY    = 7 * (CMP_LAT + 1) + 1;
    localparam int N_RANDOM   = 40;
    localparam int MAX_PAT    = 32;
    localparam int PAT_WORDS  = pool_pkg::WIN_SIZE + 1; // Nine pixels, then the maximum
    localparam int VALID_WAIT = 4 * LATENCY;

    logic              clk;
    logic              rst_n;
    logic              i_start;
    pool_pkg::window_t i_window;
    pool_pkg::pix_t    o_max;
    logic              o_valid;

    pool_pkg::pix_t pat_mem [MAX_PAT*PAT_WORDS];
    int n_patterns      = 0;
    int errors          = 0;
    int checks          = 0;
    int valid_count     = 0;
    int windows_started = 0;
    int cycle_count     = 0;
    int cycle_limit     = 2000;

    pool_3x3_max #(
        .COMPARE_LATENCY (CMP_LAT)
    ) i_pool_3x3_max (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_start  (i_start),
        .i_window (i_window),
        .o_max    (o_max),
        .o_valid  (o_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (o_valid) begin
            valid_count++; // Every finish cycle counted once
        end
    end

    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Real-number order of two halves with both zeros equal
    function automatic logic order_greater(input pool_pkg::pix_t a, input pool_pkg::pix_t b);
        logic [15:0] key_a;
        logic [15:0] key_b;
        if (a[14:0] == 15'h0 && b[14:0] == 15'h0) begin
            return 1'b0;
        end
        key_a = a[15] ? ~a : {1'b1, a[14:0]};
        key_b = b[15] ? ~b : {1'b1, b[14:0]};
        return key_a > key_b;
    endfunction

    function automatic pool_pkg::pix_t random_pixel();
        logic [31:0] r;
        pool_pkg::pix_t p;
        r = $urandom;
        p = r[15:0];
        if (p[14:10] == 5'h1f && p[9:0] != 10'h0) begin
            p[14] = 1'b0; // NaN folded to a normal value
        end
        if (p[14:0] == 15'h0) begin
            p[0] = 1'b1;
        end
        return p;
    endfunction

    function automatic pool_pkg::window_t random_window();
        pool_pkg::window_t w;
        pool_pkg::pix_t px;
        logic [31:0] r;
        w = '0;
        px = '0;
        for (int k = 0; k < pool_pkg::WIN_SIZE; k++) begin
            r = $urandom;
            if (k == 0 || r[2:0] != 3'd0) begin
                px = random_pixel(); // Otherwise repeat the neighbour
            end
            w[k*pool_pkg::PIX_W +: pool_pkg::PIX_W] = px;
        end
        return w;
    endfunction

    function automatic pool_pkg::pix_t window_max(input pool_pkg::window_t w);
        pool_pkg::pix_t m;
        pool_pkg::pix_t px;
        m = w[0 +: pool_pkg::PIX_W];
        for (int k = 1; k < pool_pkg::WIN_SIZE; k++) begin
            px = w[k*pool_pkg::PIX_W +: pool_pkg::PIX_W];
            if (order_greater(px, m)) begin
                m = px;
            end
        end
        return m;
    endfunction

    task automatic compare_pix(input string tag, input pool_pkg::pix_t got,
                               input pool_pkg::pix_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s o_max got %h expected %h", tag, got, exp);
        end
    endtask

    task automatic check_latency(input string tag, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[FAIL] %s o_valid latency got %h expected %h", tag, got, exp);
        end
    endtask

    task automatic check_quiet(input string tag);
        checks++;
        if (o_valid !== 1'b0) begin
            errors++;
            $display("[FAIL] %s o_valid got %h expected 0", tag, o_valid);
        end
        compare_pix(tag, o_max, '0);
    endtask

    task automatic wait_valid(output int waited, output logic seen);
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < VALID_WAIT) begin
            @(negedge clk);
            waited++;
            seen = o_valid;
        end
    endtask

    task automatic run_pattern(input int p);
        pool_pkg::window_t win;
        int waited;
        logic seen;
        string tag;
        tag = $sformatf("pattern %0d", p);
        for (int k = 0; k < pool_pkg::WIN_SIZE; k++) begin
            win[k*pool_pkg::PIX_W +: pool_pkg::PIX_W] = pat_mem[p*PAT_WORDS + k];
        end
        @(negedge clk);
        i_window = win;
        i_start = 1'b1;
        windows_started++;
        @(negedge clk);
        i_start = 1'b0;
        wait_valid(waited, seen);
        if (!seen) begin
            errors++;
            $display("%s: o_valid never came within %0d cycles", tag, VALID_WAIT);
        end else begin
            compare_pix(tag, o_max, pat_mem[p*PAT_WORDS + pool_pkg::WIN_SIZE]);
            check_latency(tag, waited + 1, LATENCY);
        end
    endtask

    // i_start stays high, so each window follows the previous finish
    task automatic run_back_to_back(input int count);
        pool_pkg::window_t win;
        int waited;
        logic seen;
        string tag;
        @(negedge clk);
        i_start = 1'b1;
        for (int i = 0; i < count; i++) begin
            win = random_window();
            tag = $sformatf("random %0d", i);
            i_window = win;
            windows_started++;
            wait_valid(waited, seen);
            if (i == count - 1) begin
                i_start = 1'b0;
            end
            if (!seen) begin
                errors++;
                $display("%s: o_valid never came within %0d cycles", tag, VALID_WAIT);
            end else begin
                compare_pix(tag, o_max, window_max(win));
                check_latency(tag, waited, (i == 0) ? LATENCY : LATENCY + 1);
            end
        end
    endtask

    task automatic run_busy_restart();
        pool_pkg::window_t win;
        int waited;
        logic seen;
        win = random_window();
        @(negedge clk);
        i_window = win;
        i_start = 1'b1;
        windows_started++;
        @(negedge clk);
        i_start = 1'b0;
        repeat (4) @(negedge clk);
        i_start = 1'b1; // Requests in the middle of the sort
        repeat (8) @(negedge clk);
        i_start = 1'b0;
        wait_valid(waited, seen);
        if (!seen) begin
            errors++;
            $display("busy restart: o_valid never came within %0d cycles", VALID_WAIT);
        end else begin
            compare_pix("busy restart", o_max, window_max(win));
            check_latency("busy restart", waited + 13, LATENCY); // 13 edges before the wait
        end
        repeat (30) begin
            @(negedge clk);
            checks++;
            if (o_valid) begin
                errors++;
                $display("An extra o_valid pulse followed a start raised while busy");
            end
        end
    endtask

    initial begin
        void'($urandom(32'h8997ecb5));
        rst_n = 1'b0;
        i_start = 1'b0;
        i_window = '0;
        for (int a = 0; a < MAX_PAT*PAT_WORDS; a++) begin
            pat_mem[a] = {7'h3f, a[8:0]}; // NaN fill that is never a pixel
        end
        $readmemh("test/pool_patterns.hex", pat_mem);
        while (n_patterns < MAX_PAT &&
               !(pat_mem[n_patterns*PAT_WORDS][14:10] == 5'h1f &&
                 pat_mem[n_patterns*PAT_WORDS][9:0] != 10'h0)) begin
            n_patterns++;
        end
        cycle_limit = (n_patterns + N_RANDOM) * 30 + 100;
        if (n_patterns == 0) begin
            errors++;
            $display("No patterns could be read from test/pool_patterns.hex");
        end

        repeat (8) begin
            @(negedge clk);
            check_quiet("reset");
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_quiet("idle after reset");
        end

        for (int p = 0; p < n_patterns; p++) begin
            run_pattern(p);
        end
        run_back_to_back(N_RANDOM);
        run_busy_restart();

        checks++;
        if (valid_count != windows_started) begin
            errors++;
            $display("[FAIL] o_valid pulse count got %h expected %h", valid_count,
                     windows_started);
        end
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
